// ==== design/bht.sv ====
`timescale 1ns/10ps

module bht #(
	parameter int entries = bp_pkg::bht_size
)(
	input  logic                          clk,
	input  logic                          arst_n,
	input  bp_pkg::virt_t                 pc,
	input  logic                          upd_valid,
	input  bp_pkg::virt_t                 upd_pc,
	input  logic                          upd_taken,
	output logic [bp_pkg::fetch_num-1:0]  pred_valid,
	output logic [bp_pkg::fetch_num-1:0]  pred_taken
);

// ports 0..fetch_num-1 serve the fetch slots, the last one the update
logic [bp_pkg::fetch_num:0][$clog2(entries)-1:0] rd_index;
bp_pkg::bht_entry_t [bp_pkg::fetch_num:0]        rd_data;
logic [bp_pkg::fetch_num:0]                      rd_valid;
logic [$clog2(entries)-1:0]                      upd_index;
bp_pkg::bht_entry_t                              old_cnt;
bp_pkg::bht_entry_t                              new_cnt;

for (genvar i = 0; i < bp_pkg::fetch_num; i++) begin : gen_slot
	bp_pkg::virt_t slot_pc;

	assign slot_pc       = pc + bp_pkg::virt_t'(4 * i);
	assign rd_index[i]   = slot_pc[2 +: $clog2(entries)]; // word index
	assign pred_valid[i] = rd_valid[i];
	assign pred_taken[i] = rd_data[i][1];
end

assign upd_index                   = upd_pc[2 +: $clog2(entries)];
assign rd_index[bp_pkg::fetch_num] = upd_index;
assign old_cnt                     = rd_data[bp_pkg::fetch_num];

always_comb begin
	if (!rd_valid[bp_pkg::fetch_num]) begin
		new_cnt = upd_taken ? 2'b10 : 2'b01; // first sighting starts weak
	end else if (upd_taken) begin
		new_cnt = (old_cnt == 2'b11) ? old_cnt : old_cnt + 2'b01;
	end else begin
		new_cnt = (old_cnt == 2'b00) ? old_cnt : old_cnt - 2'b01;
	end
end

pred_table #(
	.entry_t  ( bp_pkg::bht_entry_t   ),
	.entries  ( entries               ),
	.rd_ports ( bp_pkg::fetch_num + 1 )
) counter_table (
	.clk,
	.arst_n,
	.wr_en    ( upd_valid ),
	.wr_index ( upd_index ),
	.wr_data  ( new_cnt   ),
	.rd_index,
	.rd_data,
	.rd_valid
);

endmodule

// ==== design/bp_pkg.sv ====
package bp_pkg;

// fetch geometry
localparam int fetch_num = 2; // instructions per fetch pair

typedef logic [31:0] virt_t;
typedef logic [31:0] uint32_t;

typedef enum logic [2:0] {
	cf_none,
	cf_branch,   // conditional branch
	cf_jump_imm, // j / jal
	cf_jump_reg, // jr / jalr through a register
	cf_return    // jr $ra
} controlflow_t;

// default table depths
localparam int bht_size = 1024;
localparam int btb_size = 8;
localparam int ras_size = 8;

// 2-bit saturating counter, msb is the taken prediction
typedef logic [1:0] bht_entry_t;

// btb tag is the word address above the index bits
localparam int btb_tag_bits = 30 - $clog2(btb_size);

typedef struct packed {
	logic [btb_tag_bits-1:0] tag;
	virt_t                   target;
} btb_entry_t;

// mips opcodes
localparam logic [5:0] op_special = 6'b000000;
localparam logic [5:0] op_regimm  = 6'b000001; // bltz / bgez by rt
localparam logic [5:0] op_j       = 6'b000010;
localparam logic [5:0] op_jal     = 6'b000011;
localparam logic [5:0] op_beq     = 6'b000100;
localparam logic [5:0] op_bne     = 6'b000101;
localparam logic [5:0] op_blez    = 6'b000110;
localparam logic [5:0] op_bgtz    = 6'b000111;

// function field of op_special
localparam logic [5:0] fn_jr   = 6'b001000;
localparam logic [5:0] fn_jalr = 6'b001001;

// link register
localparam logic [4:0] reg_ra = 5'd31;

endpackage

// ==== design/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor (
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  bp_pkg::virt_t                                pc, // 8-byte aligned
	input  bp_pkg::uint32_t [bp_pkg::fetch_num-1:0]      instr,
	input  logic [bp_pkg::fetch_num-1:0]                 instr_valid,
	input  logic                                         stall,
	input  logic                                         flush,
	input  logic                                         resolved_valid,
	input  bp_pkg::virt_t                                resolved_pc,
	input  bp_pkg::controlflow_t                         resolved_cf,
	input  logic                                         resolved_taken,
	input  bp_pkg::virt_t                                resolved_target,
	input  logic                                         resolved_mispredict,
	output logic                                         valid,
	output bp_pkg::virt_t                                predict_vaddr,
	output logic [bp_pkg::fetch_num-1:0]                 maybe_jump,
	output bp_pkg::controlflow_t [bp_pkg::fetch_num-1:0] cf
);

bp_pkg::virt_t [bp_pkg::fetch_num-1:0]   slot_pc;
bp_pkg::uint32_t [bp_pkg::fetch_num-1:0] imm_branch;
bp_pkg::uint32_t [bp_pkg::fetch_num-1:0] imm_jump;

// raw decoder flags and their instr_valid gated versions
logic [bp_pkg::fetch_num-1:0] d_branch, d_jump_i, d_jump_r, d_call, d_return;
logic [bp_pkg::fetch_num-1:0] is_branch, is_jump_i, is_jump_r, is_call, is_return;

logic [bp_pkg::fetch_num-1:0]          bht_valid, bht_taken;
logic [bp_pkg::fetch_num-1:0]          btb_hit;
bp_pkg::virt_t [bp_pkg::fetch_num-1:0] btb_target;
logic                                  ras_valid;
bp_pkg::virt_t                         ras_top;

logic                         ras_push, ras_pop;
bp_pkg::virt_t                ras_push_data;
logic [bp_pkg::fetch_num-1:0] taken;
logic                         bht_upd, btb_upd;

for (genvar i = 0; i < bp_pkg::fetch_num; i++) begin : gen_slot
	decode_branch slot_decoder (
		.instr      ( instr[i]      ),
		.imm_branch ( imm_branch[i] ),
		.imm_jump   ( imm_jump[i]   ),
		.is_branch  ( d_branch[i]   ),
		.is_jump_i  ( d_jump_i[i]   ),
		.is_jump_r  ( d_jump_r[i]   ),
		.is_call    ( d_call[i]     ),
		.is_return  ( d_return[i]   )
	);

	assign slot_pc[i]   = pc + bp_pkg::virt_t'(4 * i);
	assign is_branch[i] = instr_valid[i] & d_branch[i];
	assign is_jump_i[i] = instr_valid[i] & d_jump_i[i];
	assign is_jump_r[i] = instr_valid[i] & d_jump_r[i] & ~d_call[i]; // jalr is a call
	assign is_call[i]   = instr_valid[i] & d_call[i];
	assign is_return[i] = instr_valid[i] & d_return[i];
	assign maybe_jump[i] = instr_valid[i]
	                       & (d_branch[i] | d_jump_i[i] | d_jump_r[i] | d_call[i] | d_return[i]);
end

// scan high to low so the oldest slot that redirects wins
always_comb begin
	ras_push      = 1'b0;
	ras_pop       = 1'b0;
	ras_push_data = '0;
	predict_vaddr = '0;
	taken         = '0;
	for (int i = 0; i < bp_pkg::fetch_num; i++) begin
		cf[i] = bp_pkg::cf_none;
	end

	for (int i = bp_pkg::fetch_num - 1; i >= 0; i--) begin
		case ({is_branch[i], is_return[i], is_jump_i[i], is_jump_r[i]})
		4'b0001: begin
			if (btb_hit[i]) begin // a btb miss falls through
				cf[i]         = bp_pkg::cf_jump_reg;
				predict_vaddr = btb_target[i];
			end
		end
		4'b0010: begin
			cf[i]         = bp_pkg::cf_jump_imm;
			predict_vaddr = {pc[31:28], imm_jump[i][27:0]};
		end
		4'b0100: begin
			ras_pop       = ras_valid;
			cf[i]         = bp_pkg::cf_return;
			predict_vaddr = ras_top;
		end
		4'b1000: begin
			// static rule is backward taken
			taken[i] = bht_valid[i] ? bht_taken[i] : instr[i][15];
			if (taken[i]) begin
				cf[i]         = bp_pkg::cf_branch;
				predict_vaddr = slot_pc[i] + imm_branch[i];
			end
		end
		default: ; // not a control flow change
		endcase

		if (is_call[i]) begin
			ras_push      = 1'b1;
			ras_push_data = slot_pc[i] + 32'd8; // skip the delay slot
		end
	end

	valid = 1'b0;
	for (int i = 0; i < bp_pkg::fetch_num; i++) begin
		valid = valid | (cf[i] != bp_pkg::cf_none);
	end
end

// training from the execute stage
assign bht_upd = resolved_valid && (resolved_cf == bp_pkg::cf_branch);
assign btb_upd = resolved_valid && resolved_mispredict
                 && (resolved_cf == bp_pkg::cf_jump_reg);

bht #(
	.entries ( bp_pkg::bht_size )
) bht_inst (
	.clk,
	.arst_n,
	.pc,
	.upd_valid  ( bht_upd        ),
	.upd_pc     ( resolved_pc    ),
	.upd_taken  ( resolved_taken ),
	.pred_valid ( bht_valid      ),
	.pred_taken ( bht_taken      )
);

btb #(
	.entries ( bp_pkg::btb_size )
) btb_inst (
	.clk,
	.arst_n,
	.pc,
	.upd_valid  ( btb_upd         ),
	.upd_pc     ( resolved_pc     ),
	.upd_target ( resolved_target ),
	.hit        ( btb_hit         ),
	.target     ( btb_target      )
);

ras #(
	.entries ( bp_pkg::ras_size )
) ras_inst (
	.clk,
	.arst_n,
	.flush,
	.push      ( ras_push & ~stall ),
	.pop       ( ras_pop & ~stall  ),
	.push_data ( ras_push_data     ),
	.top_valid ( ras_valid         ),
	.top_data  ( ras_top           )
);

endmodule

// ==== design/btb.sv ====
`timescale 1ns/10ps

module btb #(
	parameter int entries = bp_pkg::btb_size
)(
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  bp_pkg::virt_t                         pc,
	input  logic                                  upd_valid,
	input  bp_pkg::virt_t                         upd_pc,
	input  bp_pkg::virt_t                         upd_target,
	output logic [bp_pkg::fetch_num-1:0]          hit,
	output bp_pkg::virt_t [bp_pkg::fetch_num-1:0] target
);

logic [bp_pkg::fetch_num-1:0][$clog2(entries)-1:0] rd_index;
bp_pkg::btb_entry_t [bp_pkg::fetch_num-1:0]        rd_data;
logic [bp_pkg::fetch_num-1:0]                      rd_valid;
logic [$clog2(entries)-1:0]                        upd_index;
bp_pkg::btb_entry_t                                wr_data;

for (genvar i = 0; i < bp_pkg::fetch_num; i++) begin : gen_slot
	bp_pkg::virt_t slot_pc;

	assign slot_pc     = pc + bp_pkg::virt_t'(4 * i);
	assign rd_index[i] = slot_pc[2 +: $clog2(entries)];
	// tag match guards against aliasing pcs
	assign hit[i]      = rd_valid[i]
	                     && (rd_data[i].tag == slot_pc[31 -: bp_pkg::btb_tag_bits]);
	assign target[i]   = rd_data[i].target;
end

// allocate or overwrite on a register jump mispredict
assign upd_index      = upd_pc[2 +: $clog2(entries)];
assign wr_data.tag    = upd_pc[31 -: bp_pkg::btb_tag_bits];
assign wr_data.target = upd_target;

pred_table #(
	.entry_t ( bp_pkg::btb_entry_t ),
	.entries ( entries             )
) target_table (
	.clk,
	.arst_n,
	.wr_en    ( upd_valid ),
	.wr_index ( upd_index ),
	.wr_data,
	.rd_index,
	.rd_data,
	.rd_valid
);

endmodule

// ==== design/decode_branch.sv ====
`timescale 1ns/10ps

module decode_branch (
	input  bp_pkg::uint32_t instr,
	output bp_pkg::uint32_t imm_branch,
	output bp_pkg::uint32_t imm_jump,
	output logic            is_branch,
	output logic            is_jump_i,
	output logic            is_jump_r,
	output logic            is_call,
	output logic            is_return
);

logic [5:0] opcode;
logic [5:0] funct;
logic [4:0] rs;
logic [4:0] rt;
logic       special_jr;
logic       special_jalr;

assign opcode = instr[31:26];
assign funct  = instr[5:0];
assign rs     = instr[25:21];
assign rt     = instr[20:16];

assign special_jr   = (opcode == bp_pkg::op_special) && (funct == bp_pkg::fn_jr);
assign special_jalr = (opcode == bp_pkg::op_special) && (funct == bp_pkg::fn_jalr);

// branch offset is relative to the delay slot, hence the extra 4
assign imm_branch = {{14{instr[15]}}, instr[15:0], 2'b00} + 32'd4;
assign imm_jump   = {4'b0000, instr[25:0], 2'b00}; // region bits come from pc

always_comb begin
	case (opcode)
	bp_pkg::op_beq,
	bp_pkg::op_bne,
	bp_pkg::op_blez,
	bp_pkg::op_bgtz:   is_branch = 1'b1;
	bp_pkg::op_regimm: is_branch = (rt[4:1] == 4'b0000); // bltz, bgez only
	default:           is_branch = 1'b0;
	endcase
end

assign is_jump_i = (opcode == bp_pkg::op_j) || (opcode == bp_pkg::op_jal);
assign is_call   = (opcode == bp_pkg::op_jal) || special_jalr;
assign is_return = special_jr && (rs == bp_pkg::reg_ra);

// jalr shows up here too, the top level masks it out with is_call
assign is_jump_r = (special_jr || special_jalr) && !is_return;

// kinds that pick a target must never overlap
always_comb begin
	if (!$isunknown(instr)) begin
		assert final ($onehot0({is_branch, is_jump_i, is_jump_r}))
		else $error("decode_branch: overlapping branch kinds for %h", instr);
	end
end

endmodule

// ==== design/pred_table.sv ====
`timescale 1ns/10ps

module pred_table #(
	parameter type entry_t  = logic,
	parameter int  entries  = 8,
	parameter int  rd_ports = bp_pkg::fetch_num
)(
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     wr_en,
	input  logic [$clog2(entries)-1:0]               wr_index,
	input  entry_t                                   wr_data,
	input  logic [rd_ports-1:0][$clog2(entries)-1:0] rd_index,
	output entry_t [rd_ports-1:0]                    rd_data,
	output logic [rd_ports-1:0]                      rd_valid
);

entry_t             mem [entries];
logic [entries-1:0] entry_valid;

// valid bits are control state
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		entry_valid <= '0;
	end else if (wr_en) begin
		entry_valid[wr_index] <= 1'b1;
	end
end

// payload array
always_ff @(posedge clk) begin
	if (wr_en) begin
		mem[wr_index] <= wr_data;
	end
end

for (genvar i = 0; i < rd_ports; i++) begin : gen_rd
	assign rd_data[i]  = mem[rd_index[i]];   // async read
	assign rd_valid[i] = entry_valid[rd_index[i]];
end

// a write with unknown payload would poison later predictions
assert property (@(posedge clk) disable iff (!arst_n)
	wr_en |-> !$isunknown(wr_data))
else $error("pred_table: write of unknown data at index %0d", wr_index);

endmodule

// ==== design/ras.sv ====
`timescale 1ns/10ps

module ras #(
	parameter int entries = bp_pkg::ras_size
)(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          flush,
	input  logic          push,
	input  logic          pop,
	input  bp_pkg::virt_t push_data,
	output logic          top_valid,
	output bp_pkg::virt_t top_data
);

bp_pkg::virt_t              stack [entries];
logic [$clog2(entries)-1:0] top_ptr;  // slot of the current top
logic [$clog2(entries)-1:0] push_ptr;
logic [$clog2(entries):0]   depth;    // saturates at entries
logic                       replace;

assign push_ptr  = top_ptr + 1'b1; // wraps, oldest entry gets overwritten
assign replace   = push && pop && top_valid;
assign top_valid = (depth != '0);
assign top_data  = top_valid ? stack[top_ptr] : '0;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		top_ptr <= '0;
		depth   <= '0;
	end else if (flush) begin
		depth <= '0;
	end else if (push && !replace) begin
		top_ptr <= push_ptr;
		if (depth < entries) begin
			depth <= depth + 1'b1;
		end
	end else if (pop && !push && top_valid) begin
		top_ptr <= top_ptr - 1'b1;
		depth   <= depth - 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (!flush && push) begin
		if (replace) begin
			stack[top_ptr] <= push_data; // call right after return
		end else begin
			stack[push_ptr] <= push_data;
		end
	end
end

// underflow must leave the stack empty
assert property (@(posedge clk) disable iff (!arst_n)
	(pop && !push && !flush && !top_valid) |=> !top_valid)
else $error("ras: pop of empty stack was not ignored");

endmodule

// ==== tb.f ====
+incdir+test
design/bp_pkg.sv
design/decode_branch.sv
design/pred_table.sv
design/bht.sv
design/btb.sv
design/ras.sv
design/branch_predictor.sv
test/tb_branch_predictor.sv

// ==== test/bp_tb_model.svh ====
`ifndef bp_tb_model_svh
`define bp_tb_model_svh

// mirrored predictor state, stepped once per clock by the compare process
logic               m_bht_vld [bp_pkg::bht_size];
bp_pkg::bht_entry_t m_bht_cnt [bp_pkg::bht_size];
logic               m_btb_vld [bp_pkg::btb_size];
bp_pkg::virt_t      m_btb_pc  [bp_pkg::btb_size]; // full pc, tag cut on compare
bp_pkg::virt_t      m_btb_tgt [bp_pkg::btb_size];
bp_pkg::virt_t      m_ras [$];                    // back of the queue is the top

localparam int btb_tag_shift = 2 + $clog2(bp_pkg::btb_size);

function automatic void predict_ref(
	input  bp_pkg::virt_t                                p,
	input  bp_pkg::uint32_t [bp_pkg::fetch_num-1:0]      w,
	input  logic [bp_pkg::fetch_num-1:0]                 wv,
	output logic                                         v,
	output bp_pkg::virt_t                                va,
	output bp_pkg::controlflow_t [bp_pkg::fetch_num-1:0] c,
	output logic [bp_pkg::fetch_num-1:0]                 mj,
	output logic                                         push,
	output bp_pkg::virt_t                                push_addr,
	output logic                                         pop
);
	bp_pkg::virt_t a;
	bp_pkg::virt_t tgt;
	logic [5:0]    op;
	logic          br;
	logic          jr;
	logic          jalr;
	int            bi;
	int            ti;

	v         = 1'b0;
	va        = '0;
	push      = 1'b0;
	push_addr = '0;
	pop       = 1'b0;
	for (int i = 0; i < bp_pkg::fetch_num; i++) begin
		a     = p + 4 * i;
		op    = w[i][31:26];
		jr    = (op == bp_pkg::op_special) && (w[i][5:0] == bp_pkg::fn_jr);
		jalr  = (op == bp_pkg::op_special) && (w[i][5:0] == bp_pkg::fn_jalr);
		br    = (op inside {bp_pkg::op_beq, bp_pkg::op_bne, bp_pkg::op_blez, bp_pkg::op_bgtz})
		        || (op == bp_pkg::op_regimm && w[i][20:17] == 4'd0);
		mj[i] = wv[i] && (br || jr || jalr || op == bp_pkg::op_j || op == bp_pkg::op_jal);
		c[i]  = bp_pkg::cf_none;
		tgt   = '0;
		bi    = (a >> 2) % bp_pkg::bht_size;
		ti    = (a >> 2) % bp_pkg::btb_size;
		if (wv[i]) begin
			if (!push && (jalr || op == bp_pkg::op_jal)) begin
				push      = 1'b1;
				push_addr = a + 8; // link past the delay slot
			end
			if (jr && w[i][25:21] == bp_pkg::reg_ra) begin
				c[i] = bp_pkg::cf_return;
				if (m_ras.size() > 0) begin
					pop = 1'b1;
					tgt = m_ras[m_ras.size() - 1];
				end
			end else if (op == bp_pkg::op_j || op == bp_pkg::op_jal) begin
				c[i] = bp_pkg::cf_jump_imm;
				tgt  = {p[31:28], w[i][25:0], 2'b00};
			end else if (jr && m_btb_vld[ti]
			             && (m_btb_pc[ti] >> btb_tag_shift) == (a >> btb_tag_shift)) begin
				c[i] = bp_pkg::cf_jump_reg;
				tgt  = m_btb_tgt[ti];
			end else if (br && (m_bht_vld[bi] ? m_bht_cnt[bi][1] : w[i][15])) begin
				c[i] = bp_pkg::cf_branch; // cold entry falls back to backward taken
				tgt  = a + {{14{w[i][15]}}, w[i][15:0], 2'b00} + 4;
			end
		end
		if (c[i] != bp_pkg::cf_none && !v) begin
			v  = 1'b1;
			va = tgt;
		end
	end
endfunction

// ras and table effects of one rising edge
function automatic void model_clock(input logic push, input bp_pkg::virt_t push_addr,
	input logic pop, input logic st, input logic fl, input logic rv, input bp_pkg::virt_t rpc,
	input bp_pkg::controlflow_t rcf, input logic tk, input bp_pkg::virt_t rtgt, input logic mis);
	int bi;
	int ti;

	bi = (rpc >> 2) % bp_pkg::bht_size;
	ti = (rpc >> 2) % bp_pkg::btb_size;
	if (fl) begin
		m_ras.delete();
	end else if (!st && push && pop) begin
		m_ras[m_ras.size() - 1] = push_addr; // call and return in one pair
	end else if (!st && push) begin
		m_ras.push_back(push_addr);
		if (m_ras.size() > bp_pkg::ras_size) begin
			void'(m_ras.pop_front()); // oldest return is lost
		end
	end else if (!st && pop) begin
		void'(m_ras.pop_back());
	end
	if (rv && rcf == bp_pkg::cf_branch) begin
		if (!m_bht_vld[bi]) begin
			m_bht_cnt[bi] = tk ? 2'b10 : 2'b01;
		end else if (tk && m_bht_cnt[bi] != 2'b11) begin
			m_bht_cnt[bi] = m_bht_cnt[bi] + 2'b01;
		end else if (!tk && m_bht_cnt[bi] != 2'b00) begin
			m_bht_cnt[bi] = m_bht_cnt[bi] - 2'b01;
		end
		m_bht_vld[bi] = 1'b1;
	end
	if (rv && mis && rcf == bp_pkg::cf_jump_reg) begin
		m_btb_vld[ti] = 1'b1;
		m_btb_pc[ti]  = rpc;
		m_btb_tgt[ti] = rtgt;
	end
endfunction

`endif

// ==== test/tb_branch_predictor.sv ====
`timescale 1ns/10ps

module tb_branch_predictor;

localparam int clk_period     = 40;
localparam int static_vectors = 24;
localparam int jump_vectors   = 8;
localparam int call_depth     = bp_pkg::ras_size + 2; // two past full so the stack wraps
localparam int num_vectors    = static_vectors + jump_vectors + 2 * call_depth + 40;

logic                                         clk;
logic                                         arst_n;
bp_pkg::virt_t                                pc;
bp_pkg::uint32_t [bp_pkg::fetch_num-1:0]      instr;
logic [bp_pkg::fetch_num-1:0]                 instr_valid;
logic                                         stall;
logic                                         flush;
logic                                         resolved_valid;
bp_pkg::virt_t                                resolved_pc;
bp_pkg::controlflow_t                         resolved_cf;
logic                                         resolved_taken;
bp_pkg::virt_t                                resolved_target;
logic                                         resolved_mispredict;
logic                                         valid;
bp_pkg::virt_t                                predict_vaddr;
logic [bp_pkg::fetch_num-1:0]                 maybe_jump;
bp_pkg::controlflow_t [bp_pkg::fetch_num-1:0] cf;

logic                                         checking;
logic [31:0]                                  lfsr_state;
logic                                         exp_valid;
bp_pkg::virt_t                                exp_vaddr;
bp_pkg::controlflow_t [bp_pkg::fetch_num-1:0] exp_cf;
logic [bp_pkg::fetch_num-1:0]                 exp_mj;
logic                                         exp_push;
bp_pkg::virt_t                                exp_push_addr;
logic                                         exp_pop;

`include "bp_tb_model.svh"

branch_predictor DUT (.*);

initial begin
	clk = 1'b0;
	forever #(clk_period / 2) clk = ~clk;
end

// galois lfsr for x^32+x^22+x^2+x+1 stepped once per bit
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] r;

	r = '0;
	for (int k = 0; k < n; k++) begin
		r          = {r[30:0], lfsr_state[0]};
		lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
	end
	return r;
endfunction

function automatic bp_pkg::uint32_t enc_jump(input logic [5:0] op, input logic [25:0] idx);
	return {op, idx};
endfunction

function automatic bp_pkg::uint32_t enc_reg(input logic [5:0] fn, input logic [4:0] rs);
	return {bp_pkg::op_special, rs, 5'd0, 5'd31, 5'd0, fn}; // rd only used by jalr
endfunction

function automatic bp_pkg::uint32_t rand_branch();
	logic [5:0] op;

	case (take_bits(2))
	0:       op = bp_pkg::op_beq;
	1:       op = bp_pkg::op_bne;
	2:       op = bp_pkg::op_blez;
	default: op = bp_pkg::op_bgtz;
	endcase
	return {op, 10'd0, 16'(take_bits(16))};
endfunction

task automatic fail_run();
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_vaddr(input string name, input bp_pkg::virt_t got, input bp_pkg::virt_t exp);
	if (got !== exp) begin
		$display("ERROR %s got %h expected %h", name, got, exp);
		fail_run();
	end
endtask

task automatic check_cf(input string name, input bp_pkg::controlflow_t got,
                        input bp_pkg::controlflow_t exp);
	if (got !== exp) begin
		$display("ERROR %s got %h expected %h", name, got, exp);
		fail_run();
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERROR %s got %h expected %h", name, got, exp);
		fail_run();
	end
endtask

task automatic fetch(input bp_pkg::virt_t p, input bp_pkg::uint32_t w0,
                     input bp_pkg::uint32_t w1, input logic [1:0] v, input logic st,
                     input logic fl);
	@(negedge clk);
	pc             = p;
	instr          = {w1, w0};
	instr_valid    = v;
	stall          = st;
	flush          = fl;
	resolved_valid = 1'b0;
endtask

task automatic resolve(input bp_pkg::virt_t p, input bp_pkg::controlflow_t c, input logic tk,
                       input bp_pkg::virt_t tgt, input logic mis);
	@(negedge clk);
	instr_valid         = '0;
	stall               = 1'b0;
	flush               = 1'b0;
	resolved_valid      = 1'b1;
	resolved_pc         = p;
	resolved_cf         = c;
	resolved_taken      = tk;
	resolved_target     = tgt;
	resolved_mispredict = mis;
endtask

// outputs are settled a quarter period after the falling edge
always @(negedge clk) begin
	if (checking) begin
		#(clk_period / 4);
		predict_ref(pc, instr, instr_valid, exp_valid, exp_vaddr, exp_cf, exp_mj,
		            exp_push, exp_push_addr, exp_pop);
		check_flag("valid", valid, exp_valid);
		if (exp_valid) begin
			check_vaddr("predict_vaddr", predict_vaddr, exp_vaddr);
		end
		for (int i = 0; i < bp_pkg::fetch_num; i++) begin
			check_cf($sformatf("cf[%0d]", i), cf[i], exp_cf[i]);
			check_flag($sformatf("maybe_jump[%0d]", i), maybe_jump[i], exp_mj[i]);
		end
		model_clock(exp_push, exp_push_addr, exp_pop, stall, flush, resolved_valid, resolved_pc,
		            resolved_cf, resolved_taken, resolved_target, resolved_mispredict);
	end
end

initial begin
	#(num_vectors * clk_period * 4);
	$display("timeout, the predictor tests did not finish in time");
	fail_run();
end

initial begin : stimulus
	bp_pkg::virt_t   a;
	bp_pkg::uint32_t w;
	bp_pkg::uint32_t ret_w;

	lfsr_state          = 32'd84475;
	checking            = 1'b0;
	arst_n              = 1'b0;
	pc                  = '0;
	instr               = '0;
	instr_valid         = '0;
	stall               = 1'b0;
	flush               = 1'b0;
	resolved_valid      = 1'b0;
	resolved_pc         = '0;
	resolved_cf         = bp_pkg::cf_none;
	resolved_taken      = 1'b0;
	resolved_target     = '0;
	resolved_mispredict = 1'b0;
	m_bht_vld           = '{default: 1'b0};
	m_btb_vld           = '{default: 1'b0};
	m_ras.delete();
	ret_w               = enc_reg(bp_pkg::fn_jr, bp_pkg::reg_ra);
	repeat (2) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
	@(posedge clk);
	checking = 1'b1;

	// cold tables predict branches by offset sign
	repeat (static_vectors) begin
		a = {29'(take_bits(29)), 3'b000};
		fetch(a, rand_branch(), rand_branch(), 2'(take_bits(2)), 1'b0, 1'b0);
	end

	// offset -1 still counts as backward
	fetch(32'h0000_1200, {bp_pkg::op_bne, 10'd0, 16'hffff}, '0, 2'b01, 1'b0, 1'b0);

	// j in slot 0, jal in slot 1
	for (int k = 0; k < jump_vectors; k++) begin
		a = {29'(take_bits(29)), 3'b000};
		fetch(a, enc_jump(bp_pkg::op_j, 26'(take_bits(26))),
		      enc_jump(bp_pkg::op_jal, 26'(take_bits(26))), 2'(k % 4), 1'b0, 1'b0);
	end

	// calls and returns
	a = 32'h0040_1000;
	fetch('0, '0, '0, 2'b00, 1'b0, 1'b1);
	fetch(a, '0, enc_jump(bp_pkg::op_jal, 26'h10_0400), 2'b11, 1'b0, 1'b0);
	fetch(32'h0041_0000, ret_w, '0, 2'b01, 1'b0, 1'b0); // back to a + 12
	fetch(a, enc_jump(bp_pkg::op_jal, 26'h10_0400), '0, 2'b01, 1'b1, 1'b0); // lost in stall
	fetch(32'h0041_0000, ret_w, '0, 2'b01, 1'b0, 1'b0);
	for (int k = 0; k < call_depth; k++) begin
		fetch(a + 32'(16 * k), enc_reg(bp_pkg::fn_jalr, 5'd9), '0, 2'b01, 1'b0, 1'b0);
	end
	for (int k = 0; k < call_depth; k++) begin
		fetch(32'h0041_0000, ret_w, '0, 2'b01, 1'b0, 1'b0);
	end
	fetch(a, enc_jump(bp_pkg::op_jal, 26'h0), '0, 2'b01, 1'b0, 1'b0);
	fetch(a + 32'h40, enc_jump(bp_pkg::op_jal, 26'h0), ret_w, 2'b11, 1'b0, 1'b0);
	fetch(32'h0041_0000, ret_w, '0, 2'b01, 1'b0, 1'b0);
	fetch(a, enc_jump(bp_pkg::op_jal, 26'h0), '0, 2'b01, 1'b0, 1'b0);
	fetch('0, '0, '0, 2'b00, 1'b0, 1'b1);
	fetch(32'h0041_0000, ret_w, '0, 2'b01, 1'b0, 1'b0); // empty after flush

	// train a backward branch down and back up
	a = 32'h0000_2460;
	w = {bp_pkg::op_bne, 10'd0, 16'hfff0};
	fetch(a, w, {bp_pkg::op_beq, 10'd0, 16'h0008}, 2'b11, 1'b0, 1'b0);
	repeat (2) begin
		resolve(a, bp_pkg::cf_branch, 1'b0, '0, 1'b0);
		fetch(a, w, {bp_pkg::op_beq, 10'd0, 16'h0008}, 2'b11, 1'b0, 1'b0);
	end
	repeat (2) begin
		resolve(a, bp_pkg::cf_branch, 1'b1, '0, 1'b0);
		fetch(a, w, {bp_pkg::op_beq, 10'd0, 16'h0008}, 2'b11, 1'b0, 1'b0);
	end

	// register jump through the btb
	a = 32'h0000_3100;
	w = enc_reg(bp_pkg::fn_jr, 5'd5);
	fetch(a, '0, w, 2'b10, 1'b0, 1'b0);
	resolve(a + 4, bp_pkg::cf_jump_reg, 1'b1, 32'h0000_7000, 1'b0); // correct so no write
	fetch(a, '0, w, 2'b10, 1'b0, 1'b0);
	resolve(a + 4, bp_pkg::cf_jump_reg, 1'b1, 32'h0000_7000, 1'b1);
	fetch(a, '0, w, 2'b10, 1'b0, 1'b0);
	fetch(a + 32'h20, '0, w, 2'b10, 1'b0, 1'b0); // same index with another tag
	fetch(a, '0, enc_reg(bp_pkg::fn_jalr, 5'd5), 2'b10, 1'b0, 1'b0);

	@(posedge clk);
	$display("Testbench passed");
	$finish;
end

endmodule
